//--- hdl/weight_buf_params.svh
// Sizing macros for the weight buffer SRAM, loader and fetcher
`ifndef WEIGHT_BUF_PARAMS_SVH
`define WEIGHT_BUF_PARAMS_SVH

// Word address and data
`define WB_ADDR_W 11
`define WB_DATA_W 128

// Write lanes
`define WB_LANES 8
`define WB_LANE_W 16

// Usable words in the macro, below the full 2^11 address space
`define WB_DEPTH 2016

// Longest fetch burst
`define WB_MAX_BURST 16

`endif

//--- hdl/wb_mem_pkg.sv
// Memory-side types shared by the SRAM ports and their drivers
`include "weight_buf_params.svh"

package wb_mem_pkg;

  // Word address into the weight SRAM
  typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

  // One weight word, eight 16-bit lanes
  typedef logic [`WB_DATA_W-1:0] wb_word_t;

  // Lane mask, active high at the loader and active low at the macro
  typedef logic [`WB_LANES-1:0] wb_lane_t;

endpackage

//--- hdl/wb_ctrl_pkg.sv
// Control-side enums for the weight loader and weight fetcher

package wb_ctrl_pkg;

  // Loader FSM
  typedef enum logic {
    LD_IDLE,
    LD_WRITE
  } load_state_e;

  // Fetcher FSM
  typedef enum logic {
    FT_IDLE,
    FT_READ
  } fetch_state_e;

  // Fetch command opcodes
  typedef enum logic {
    OP_SINGLE,
    OP_BURST
  } fetch_op_e;

endpackage

//--- hdl/weight_sram.sv
// Behavioral dual-port weight SRAM with lane writes and output-enabled reads
`timescale 1ns/1ps
`include "weight_buf_params.svh"

module weight_sram (
  input  logic                 CK,
  input  wb_mem_pkg::wb_addr_t A,
  input  wb_mem_pkg::wb_addr_t B,
  input  wb_mem_pkg::wb_word_t DIA,
  input  wb_mem_pkg::wb_word_t DIB,
  input  wb_mem_pkg::wb_lane_t WEAN,
  input  wb_mem_pkg::wb_lane_t WEBN,
  input  logic                 CSA,
  input  logic                 CSB,
  input  logic                 OEA,
  input  logic                 OEB,
  output wb_mem_pkg::wb_word_t DOA,
  output wb_mem_pkg::wb_word_t DOB
);
  import wb_mem_pkg::*;

  wb_word_t mem [`WB_DEPTH];

  // Lane writes, port B lands last on a shared address
  always_ff @(posedge CK) begin
    for (int i = 0; i < `WB_LANES; i++) begin
      if (CSA && !WEAN[i] && (A < `WB_DEPTH)) begin
        mem[A][i*`WB_LANE_W +: `WB_LANE_W] <= DIA[i*`WB_LANE_W +: `WB_LANE_W];
      end
      if (CSB && !WEBN[i] && (B < `WB_DEPTH)) begin
        mem[B][i*`WB_LANE_W +: `WB_LANE_W] <= DIB[i*`WB_LANE_W +: `WB_LANE_W];
      end
    end
  end

  // Read registers hold their last word while disabled
  always_ff @(posedge CK) begin
    if (CSA && OEA) begin
      DOA <= mem[A];
    end
    if (CSB && OEB) begin
      DOB <= mem[B];
    end
  end

endmodule

//--- hdl/weight_wrapper.sv
// Weight SRAM wrapper with same-address collision steering between ports
`timescale 1ns/1ps

module weight_wrapper (
  input  logic                 CK,
  input  logic                 OEA,
  input  logic                 OEB,
  input  wb_mem_pkg::wb_lane_t WEAN,
  input  wb_mem_pkg::wb_lane_t WEBN,
  input  wb_mem_pkg::wb_addr_t A,
  input  wb_mem_pkg::wb_addr_t B,
  input  wb_mem_pkg::wb_word_t DIA,
  input  wb_mem_pkg::wb_word_t DIB,
  output wb_mem_pkg::wb_word_t DOA,
  output wb_mem_pkg::wb_word_t DOB
);
  import wb_mem_pkg::*;

  wb_addr_t a_steer;
  wb_addr_t b_steer;

  // ======================================================================
  // Collision steering
  // ======================================================================
  // A read on port A wins the address; otherwise a port B write pushes
  // port A to the neighbouring word
  always_comb begin
    a_steer = A;
    b_steer = B;
    if (A == B) begin
      if (OEA) begin
        b_steer = B ^ wb_addr_t'(1);
      end else if (WEBN != '1) begin
        a_steer = A ^ wb_addr_t'(1);
      end
    end
  end

  weight_sram u_sram (
    .CK   (CK),
    .A    (a_steer),
    .B    (b_steer),
    .DIA  (DIA),
    .DIB  (DIB),
    .WEAN (WEAN),
    .WEBN (WEBN),
    .CSA  (1'b1),
    .CSB  (1'b1),
    .OEA  (OEA),
    .OEB  (OEB),
    .DOA  (DOA),
    .DOB  (DOB)
  );

  // Loader and fetcher never write one word together
  a_dual_write: assert property (@(posedge CK)
    !((WEAN != '1) && (WEBN != '1) && (A == B)));

endmodule

//--- hdl/weight_loader.sv
// Sequential write engine from the DMA weight stream into SRAM port B
`timescale 1ns/1ps
`include "weight_buf_params.svh"

module weight_loader (
  input  logic                 CK,
  input  logic                 reset,
  input  logic                 ld_valid,
  input  logic                 ld_first,
  output logic                 ld_ready,
  input  wb_mem_pkg::wb_addr_t ld_addr,
  input  wb_mem_pkg::wb_word_t ld_data,
  input  wb_mem_pkg::wb_lane_t ld_lanes,
  output logic                 ld_overflow,
  output wb_mem_pkg::wb_addr_t B,
  output wb_mem_pkg::wb_word_t DIB,
  output wb_mem_pkg::wb_lane_t WEBN
);
  import wb_mem_pkg::*;
  import wb_ctrl_pkg::*;

  load_state_e state;
  wb_addr_t    wr_ptr;
  wb_addr_t    beat_addr;
  logic        beat;
  logic        take;
  logic        in_range;

  // Never stalls
  assign ld_ready = 1'b1;

  assign beat      = ld_valid && ld_ready;
  assign beat_addr = ld_first ? ld_addr : wr_ptr;
  assign in_range  = beat_addr < `WB_DEPTH;
  // Stray beats before a first beat have no address
  assign take      = beat && (ld_first || (state == LD_WRITE));

  always_ff @(posedge CK) begin
    if (reset) begin
      state       <= LD_IDLE;
      wr_ptr      <= '0;
      WEBN        <= '1;
      ld_overflow <= 1'b0;
    end else begin
      WEBN <= '1;
      if (take) begin
        if (ld_first) begin
          ld_overflow <= 1'b0;
        end
        if (in_range) begin
          state  <= LD_WRITE;
          wr_ptr <= beat_addr + wb_addr_t'(1);
          WEBN   <= ~ld_lanes;
        end else begin
          // Rest of the burst is dropped
          state       <= LD_IDLE;
          ld_overflow <= 1'b1;
        end
      end
    end
  end

  // Write address and data for the macro
  always_ff @(posedge CK) begin
    if (take) begin
      B   <= beat_addr;
      DIB <= ld_data;
    end
  end

  a_wr_in_range: assert property (@(posedge CK) disable iff (reset)
    (WEBN != '1) |-> (B < `WB_DEPTH));

endmodule

//--- hdl/weight_fetcher.sv
// Command-driven read engine on SRAM port A with a two-entry skid buffer
`timescale 1ns/1ps
`include "weight_buf_params.svh"

module weight_fetcher (
  input  logic                  CK,
  input  logic                  reset,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  wb_ctrl_pkg::fetch_op_e cmd_op,
  input  wb_mem_pkg::wb_addr_t  cmd_addr,
  input  logic [4:0]            cmd_len,
  output wb_mem_pkg::wb_addr_t  A,
  output logic                  OEA,
  input  wb_mem_pkg::wb_word_t  DOA,
  output logic                  w_valid,
  input  logic                  w_ready,
  output wb_mem_pkg::wb_word_t  w_data
);
  import wb_mem_pkg::*;
  import wb_ctrl_pkg::*;

  fetch_state_e state;
  wb_addr_t     rd_addr;
  logic [4:0]   rd_left;
  logic [4:0]   out_left;
  logic         rd_pend;
  logic [1:0]   skid_cnt;
  wb_word_t     skid0;
  wb_word_t     skid1;
  logic         cmd_take;
  logic         pop;
  logic         issue;
  logic [1:0]   slots_used;

  assign cmd_ready = (state == FT_IDLE);
  assign cmd_take  = cmd_valid && cmd_ready;

  assign w_valid = (skid_cnt != 2'd0);
  assign w_data  = skid0;
  assign pop     = w_valid && w_ready;

  // ======================================================================
  // Read issue
  // ======================================================================
  // Read in flight plus buffered words, less the one leaving this cycle
  assign slots_used = skid_cnt + {1'b0, rd_pend} - {1'b0, pop};
  assign issue      = (state == FT_READ) && (rd_left != 5'd0) && (slots_used < 2'd2);

  assign A   = rd_addr;
  assign OEA = issue;

  always_ff @(posedge CK) begin
    if (reset) begin
      state    <= FT_IDLE;
      rd_left  <= '0;
      out_left <= '0;
      rd_pend  <= 1'b0;
      skid_cnt <= '0;
    end else begin
      rd_pend  <= issue;
      skid_cnt <= skid_cnt + {1'b0, rd_pend} - {1'b0, pop};
      if (cmd_take) begin
        state    <= FT_READ;
        rd_left  <= (cmd_op == OP_SINGLE) ? 5'd1 : cmd_len;
        out_left <= (cmd_op == OP_SINGLE) ? 5'd1 : cmd_len;
      end else begin
        if (issue) begin
          rd_left <= rd_left - 5'd1;
        end
        if (pop) begin
          out_left <= out_left - 5'd1;
          if (out_left == 5'd1) begin
            state <= FT_IDLE;
          end
        end
      end
    end
  end

  always_ff @(posedge CK) begin
    if (cmd_take) begin
      rd_addr <= cmd_addr;
    end else if (issue) begin
      rd_addr <= rd_addr + wb_addr_t'(1);
    end
  end

  // ======================================================================
  // Skid buffer, head in skid0
  // ======================================================================
  always_ff @(posedge CK) begin
    if (pop) begin
      skid0 <= (rd_pend && (skid_cnt == 2'd1)) ? DOA : skid1;
      if (rd_pend && (skid_cnt == 2'd2)) begin
        skid1 <= DOA;
      end
    end else if (rd_pend) begin
      if (skid_cnt == 2'd0) begin
        skid0 <= DOA;
      end else begin
        skid1 <= DOA;
      end
    end
  end

  a_hold_stalled: assert property (@(posedge CK) disable iff (reset)
    (w_valid && !w_ready) |=> (w_valid && $stable(w_data)));

  a_burst_len: assert property (@(posedge CK) disable iff (reset)
    (cmd_take && (cmd_op == OP_BURST)) |-> ((cmd_len != 5'd0) && (cmd_len <= `WB_MAX_BURST)));

endmodule

//--- hdl/weight_buf_top.sv
// Weight buffer top level joining the loader, SRAM wrapper and fetcher
`timescale 1ns/1ps

module weight_buf_top (
  input  logic                   CK,
  input  logic                   reset,
  // DMA weight stream
  input  logic                   ld_valid,
  output logic                   ld_ready,
  input  logic                   ld_first,
  input  wb_mem_pkg::wb_addr_t   ld_addr,
  input  wb_mem_pkg::wb_word_t   ld_data,
  input  wb_mem_pkg::wb_lane_t   ld_lanes,
  output logic                   ld_overflow,
  // PE array commands
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  wb_ctrl_pkg::fetch_op_e cmd_op,
  input  wb_mem_pkg::wb_addr_t   cmd_addr,
  input  logic [4:0]             cmd_len,
  // Weight words out
  output logic                   w_valid,
  input  logic                   w_ready,
  output wb_mem_pkg::wb_word_t   w_data
);
  import wb_mem_pkg::*;

  wb_addr_t b_addr;
  wb_word_t b_data;
  wb_lane_t b_webn;
  wb_addr_t a_addr;
  logic     a_oe;
  wb_word_t a_dout;

  weight_loader u_loader (
    .CK          (CK),
    .reset       (reset),
    .ld_valid    (ld_valid),
    .ld_first    (ld_first),
    .ld_ready    (ld_ready),
    .ld_addr     (ld_addr),
    .ld_data     (ld_data),
    .ld_lanes    (ld_lanes),
    .ld_overflow (ld_overflow),
    .B           (b_addr),
    .DIB         (b_data),
    .WEBN        (b_webn)
  );

  // Port A only reads and port B only writes
  weight_wrapper u_wrapper (
    .CK   (CK),
    .OEA  (a_oe),
    .OEB  (1'b0),
    .WEAN ('1),
    .WEBN (b_webn),
    .A    (a_addr),
    .B    (b_addr),
    .DIA  ('0),
    .DIB  (b_data),
    .DOA  (a_dout),
    .DOB  ()
  );

  weight_fetcher u_fetcher (
    .CK        (CK),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .A         (a_addr),
    .OEA       (a_oe),
    .DOA       (a_dout),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w_data    (w_data)
  );

endmodule

//--- testbench/tb_weight_buf.sv
// Directed testbench for the weight buffer against a reference memory model
`timescale 1ns/1ps
`include "weight_buf_params.svh"

module tb_weight_buf;
  import wb_mem_pkg::*;
  import wb_ctrl_pkg::*;

  localparam int SEED    = 71;
  localparam int TIMEOUT = 200;

  logic       CK;
  logic       reset;
  logic       ld_valid;
  logic       ld_ready;
  logic       ld_first;
  wb_addr_t   ld_addr;
  wb_word_t   ld_data;
  wb_lane_t   ld_lanes;
  logic       ld_overflow;
  logic       cmd_valid;
  logic       cmd_ready;
  fetch_op_e  cmd_op;
  wb_addr_t   cmd_addr;
  logic [4:0] cmd_len;
  logic       w_valid;
  logic       w_ready;
  wb_word_t   w_data;

  // Expected SRAM contents
  wb_word_t model [1 << `WB_ADDR_W];
  int       errors;
  int       checks;
  bit       timed_out;
  wb_addr_t base;

  weight_buf_top dut0 (.*);

  always #4 CK = ~CK;

  function automatic wb_word_t rand_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic next_cycle();
    @(posedge CK);
    #1;
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic merge_lanes(input wb_addr_t a, input wb_word_t d, input wb_lane_t lanes);
    for (int i = 0; i < `WB_LANES; i++) begin
      if (lanes[i]) begin
        model[a][i*`WB_LANE_W +: `WB_LANE_W] = d[i*`WB_LANE_W +: `WB_LANE_W];
      end
    end
  endtask

  // ==================================================================
  // Stream and command drivers
  // ==================================================================
  task automatic load_burst(input wb_addr_t start, input int n, input bit rand_lanes);
    int       waited;
    bit       dropped;
    wb_addr_t a;
    dropped = 1'b0;
    for (int i = 0; i < n; i++) begin
      a        = start + wb_addr_t'(i);
      ld_valid = 1'b1;
      ld_first = (i == 0);
      ld_addr  = start;
      ld_data  = rand_word();
      ld_lanes = rand_lanes ? wb_lane_t'($urandom) : '1;
      waited   = 0;
      while (!ld_ready) begin
        next_cycle();
        waited++;
        if (waited > TIMEOUT) begin
          note_timeout("ld_ready");
          ld_valid = 1'b0;
          return;
        end
      end
      // Once past the last word the rest of the burst is lost
      if (dropped || (int'(a) >= `WB_DEPTH)) begin
        dropped = 1'b1;
      end else begin
        merge_lanes(a, ld_data, ld_lanes);
      end
      next_cycle();
    end
    ld_valid = 1'b0;
    ld_first = 1'b0;
  endtask

  task automatic send_cmd(input fetch_op_e op, input wb_addr_t a, input logic [4:0] len);
    int waited;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = a;
    cmd_len   = len;
    waited    = 0;
    while (!cmd_ready) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("cmd_ready");
        cmd_valid = 1'b0;
        return;
      end
    end
    next_cycle();
    cmd_valid = 1'b0;
  endtask

  // Collects n words in address order, checks hold while stalled
  task automatic receive_words(input wb_addr_t start, input int n, input bit stall);
    int       got;
    int       waited;
    bit       stalled;
    wb_word_t held;
    wb_addr_t a;
    got     = 0;
    waited  = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < n) begin
      w_ready = stall ? 1'($urandom) : 1'b1;
      if (stalled) begin
        checks++;
        if (w_valid !== 1'b1 || w_data !== held) begin
          errors++;
          $display("** Error: w_data while stalled got %h (w_valid %h) expected %h",
                   w_data, w_valid, held);
        end
      end
      if (w_valid && w_ready) begin
        a = start + wb_addr_t'(got);
        checks++;
        if (w_data !== model[a]) begin
          errors++;
          $display("** Error: w_data at address %h got %h expected %h", a, w_data, model[a]);
        end
        got++;
      end
      stalled = w_valid && !w_ready;
      held    = w_data;
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("w_valid");
        w_ready = 1'b0;
        return;
      end
    end
    w_ready = 1'b0;
  endtask

  task automatic fetch_single(input wb_addr_t a);
    send_cmd(OP_SINGLE, a, 5'd0);
    if (!timed_out) begin
      receive_words(a, 1, 1'b0);
    end
  endtask

  task automatic fetch_burst(input wb_addr_t a, input logic [4:0] len, input bit stall);
    send_cmd(OP_BURST, a, len);
    if (!timed_out) begin
      receive_words(a, int'(len), stall);
    end
    checks++;
    if (!timed_out && (w_valid !== 1'b0 || cmd_ready !== 1'b1)) begin
      errors++;
      $display("** Error: after a burst of %0d w_valid got %h expected 0, cmd_ready got %h expected 1",
               len, w_valid, cmd_ready);
    end
  endtask

  // ==================================================================
  // Directed tests
  // ==================================================================
  task automatic check_reset_state();
    checks += 3;
    if (w_valid !== 1'b0) begin
      errors++;
      $display("** Error: w_valid after reset got %h expected 0", w_valid);
    end
    if (ld_overflow !== 1'b0) begin
      errors++;
      $display("** Error: ld_overflow after reset got %h expected 0", ld_overflow);
    end
    if (cmd_ready !== 1'b1) begin
      errors++;
      $display("** Error: cmd_ready after reset got %h expected 1", cmd_ready);
    end
  endtask

  task automatic full_write_readback();
    // Even base keeps a word and its bit-0 neighbour in the block
    base = wb_addr_t'(($urandom % 1000) * 2);
    load_burst(base, 16, 1'b0);
    for (int i = 0; i < 16 && !timed_out; i++) begin
      fetch_single(base + wb_addr_t'(i));
    end
  endtask

  task automatic lane_mask_update();
    load_burst(base, 16, 1'b1);
    if (!timed_out) begin
      fetch_burst(base, 5'd16, 1'b0);
    end
  endtask

  task automatic overflow_drop();
    load_burst(wb_addr_t'(2014), 5, 1'b0);
    checks++;
    if (ld_overflow !== 1'b1) begin
      errors++;
      $display("** Error: ld_overflow got %h expected 1", ld_overflow);
    end
    if (!timed_out) begin
      fetch_single(wb_addr_t'(2014));
    end
    if (!timed_out) begin
      fetch_single(wb_addr_t'(2015));
    end
  endtask

  task automatic collision_steer();
    wb_addr_t x;
    wb_word_t fresh;
    x     = base + wb_addr_t'(4);
    fresh = rand_word();
    // Command and first beat accepted on one edge, so both ports hit x together
    cmd_valid = 1'b1;
    cmd_op    = OP_SINGLE;
    cmd_addr  = x;
    cmd_len   = 5'd0;
    ld_valid  = 1'b1;
    ld_first  = 1'b1;
    ld_addr   = x;
    ld_data   = fresh;
    ld_lanes  = '1;
    checks++;
    if (cmd_ready !== 1'b1 || ld_ready !== 1'b1) begin
      errors++;
      $display("** Error: collision cycle cmd_ready got %h, ld_ready got %h, expected 1 and 1",
               cmd_ready, ld_ready);
    end
    next_cycle();
    cmd_valid = 1'b0;
    ld_valid  = 1'b0;
    ld_first  = 1'b0;
    receive_words(x, 1, 1'b0);
    // The read keeps x, the write lands on its neighbour
    merge_lanes(x ^ wb_addr_t'(1), fresh, '1);
    if (!timed_out) begin
      fetch_single(x ^ wb_addr_t'(1));
    end
    if (!timed_out) begin
      fetch_single(x);
    end
    checks++;
    if (ld_overflow !== 1'b0) begin
      errors++;
      $display("** Error: ld_overflow after a first beat got %h expected 0", ld_overflow);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    CK        = 1'b0;
    reset     = 1'b1;
    ld_valid  = 1'b0;
    ld_first  = 1'b0;
    ld_addr   = '0;
    ld_data   = '0;
    ld_lanes  = '0;
    cmd_valid = 1'b0;
    cmd_op    = OP_SINGLE;
    cmd_addr  = '0;
    cmd_len   = '0;
    w_ready   = 1'b0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    base      = '0;
    repeat (4) @(posedge CK);
    #1;
    reset = 1'b0;

    check_reset_state();
    full_write_readback();
    if (!timed_out) lane_mask_update();
    if (!timed_out) fetch_burst(base, 5'd16, 1'b1);
    if (!timed_out) overflow_drop();
    if (!timed_out) collision_steer();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- weight_buf.f
+incdir+hdl
hdl/wb_mem_pkg.sv
hdl/wb_ctrl_pkg.sv
hdl/weight_sram.sv
hdl/weight_wrapper.sv
hdl/weight_loader.sv
hdl/weight_fetcher.sv
hdl/weight_buf_top.sv
testbench/tb_weight_buf.sv

//--- Makefile
# Verilator flow for the weight buffer

TOP := tb_weight_buf

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f weight_buf.f --top-module weight_buf_top

# A nonzero exit from the binary also counts as a failed run
sim:
	verilator --binary --timing --assert -f weight_buf.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
